// File: core_ctrl.f
+incdir+src
src/ctrl_pkg.sv
src/rf_hazard_if.sv
src/ctrl_fsm.sv
src/hazard_unit.sv
src/fwd_unit.sv
src/core_ctrl.sv
verif/tb_clk_gen.sv
verif/tb_core_ctrl.sv

// File: verif/core_ctrl_trace.txt
# in: pipe dec jmp irq we wa_ex wa_id hit lsu   out: fetch stat irq csr cause haz fwd
# one cycle per line, all hex, bit packing as in drive_inputs and check_outputs
01 00 00 00 0 00 00 000 0   41 10 00 0 00 4 00
11 00 00 00 0 00 00 000 0   41 10 00 0 00 4 00
11 00 00 00 0 00 00 000 0   c1 10 00 0 00 4 00
11 00 00 00 0 00 00 000 0   81 18 00 0 00 4 00
15 00 00 00 0 00 00 000 0   81 18 00 0 00 4 00
1d 00 03 00 0 00 00 000 0   81 14 00 0 00 0 00
1d 00 10 00 0 00 00 000 0   d9 10 00 0 00 4 00
19 00 04 00 0 00 00 000 0   d1 14 00 0 00 0 00
19 00 04 00 0 00 00 000 0   91 14 00 0 00 0 00
1d 00 04 00 0 00 00 000 0   91 14 00 0 00 0 00
1d 20 00 00 0 00 00 000 0   81 17 00 6 02 4 00
1d 20 00 00 0 00 00 000 0   81 13 00 0 00 4 00
1f 20 00 00 0 00 00 000 0   81 13 00 0 00 4 00
1d 20 00 00 0 00 00 000 0   e0 13 00 0 00 4 00
1d 10 00 00 0 00 00 000 0   81 17 00 6 0b 0 00
1f 10 00 00 0 00 00 000 0   81 13 00 0 00 4 00
1d 10 00 00 0 00 00 000 0   e0 13 00 0 00 4 00
1d 08 00 00 0 00 00 000 0   81 17 00 6 03 0 00
1f 08 00 00 0 00 00 000 0   81 13 00 0 00 4 00
1d 08 00 00 0 00 00 000 0   e0 13 00 0 00 4 00
1d 04 00 00 0 00 00 000 0   81 17 00 1 00 0 00
1f 04 00 00 0 00 00 000 0   81 13 00 0 00 4 00
1d 04 00 00 0 00 00 000 0   e9 13 00 0 00 4 00
1d 00 00 e5 0 00 00 000 0   81 17 05 0 00 0 00
1d 00 00 e5 0 00 00 000 0   81 13 05 0 00 4 00
1d 00 00 e5 0 00 00 000 0   e1 10 c5 6 25 4 00
1d 00 00 c5 0 00 00 000 0   81 14 25 0 00 0 00
1d 00 00 e5 0 00 00 000 0   81 17 05 0 00 0 00
1d 00 00 25 0 00 00 000 0   81 13 25 0 00 4 00
1d 02 00 00 0 00 00 000 0   81 17 00 0 00 0 00
1f 02 00 00 0 00 00 000 0   81 13 00 0 00 4 00
1d 02 00 00 0 00 00 000 0   81 13 00 0 00 4 00
15 00 00 00 0 00 00 000 0   01 03 00 0 00 4 00
15 00 00 00 0 00 00 000 0   01 03 00 0 00 4 00
15 00 00 80 0 00 00 000 0   01 03 00 0 00 4 00
15 00 00 00 0 00 00 000 0   81 18 00 0 00 4 00
1d 00 00 00 c 0a 0b 001 0   81 14 00 0 00 6 00
1d 00 00 00 c 0a 0a 000 0   81 14 00 0 00 6 00
1c 00 00 00 2 0a 0b 012 0   81 14 00 0 00 6 08
1d 00 08 00 1 00 00 040 0   91 14 00 0 00 5 10
1d 00 08 00 0 00 00 000 0   d1 14 00 0 00 0 00
1d 00 00 00 3 00 00 068 0   81 14 00 0 00 0 12
1d 00 00 00 2 00 00 030 3   81 14 00 0 00 0 12
1d 00 00 00 2 00 00 008 1   81 14 00 0 00 0 21
1d 00 00 00 0 00 00 1ff 0   81 14 00 0 00 0 00
15 00 00 00 0 00 00 000 0   81 10 00 0 00 4 00

// File: verif/tb_core_ctrl.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Core controller testbench
//////////////////////////////////////////////////////////////////////

`include "ctrl_settings.svh"

module tb_core_ctrl;

  import ctrl_pkg::*;

  localparam int CLK_PERIOD  = 40;
  localparam int DRIVE_DELAY = 2;
  // sample 2 ns before the next rising edge
  localparam int CHECK_DELAY = CLK_PERIOD - 2 * DRIVE_DELAY;
  localparam int NUM_FIELDS  = 16;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i, wb_ready_i;
  logic illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, pipe_flush_i, csr_status_i;
  logic branch_taken_ex_i;
  jump_e jump_in_dec_i;
  jump_e jump_in_id_i;
  logic irq_i, irq_req_ctrl_i, m_ie_i;
  logic [`IRQ_ID_W-1:0] irq_id_ctrl_i;
  logic data_req_ex_i, regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i;
  logic [`REG_ADDR_W-1:0] regfile_waddr_ex_i;
  logic [`REG_ADDR_W-1:0] regfile_alu_waddr_id_i;
  logic reg_d_ex_is_reg_a_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_c_i;
  logic reg_d_wb_is_reg_a_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_c_i;
  logic reg_d_alu_is_reg_a_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_c_i;
  logic data_misaligned_i, mult_multicycle_i;

  // DUT outputs
  logic instr_req_o, pc_set_o;
  pc_mux_e pc_mux_o;
  exc_pc_mux_e exc_pc_mux_o;
  logic ctrl_busy_o, first_fetch_o, is_decoding_o, halt_if_o, halt_id_o;
  logic irq_ack_o, exc_ack_o, exc_kill_o;
  logic [`IRQ_ID_W-1:0] irq_id_o;
  logic csr_save_if_o, csr_save_id_o, csr_save_cause_o, csr_restore_mret_o;
  cause_u csr_cause_o;
  logic deassert_we_o, load_stall_o, jr_stall_o;
  fwd_sel_e operand_a_fw_sel_o, operand_b_fw_sel_o, operand_c_fw_sel_o;

  // one entry per hex field, NUM_FIELDS per trace line
  logic [15:0] trace_q [$];
  int   n_lines;
  int   line_no;
  logic loaded;

  tb_clk_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(10)) clk_gen_i (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  core_ctrl dut_i (.*);

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [15:0] expected,
                             input logic [15:0] actual);
    if (actual !== expected)
      abort_run($sformatf("Mismatch %s: expected 0x%0h, actual 0x%0h (trace line %0d)",
                          name, expected, actual, line_no));
  endtask

  task automatic init_inputs();
    {fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i, wb_ready_i} = '0;
    {illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, pipe_flush_i, csr_status_i} = '0;
    branch_taken_ex_i = 1'b0;
    jump_in_dec_i     = BRANCH_NONE;
    jump_in_id_i      = BRANCH_NONE;
    {irq_i, irq_req_ctrl_i, m_ie_i, irq_id_ctrl_i} = '0;
    {data_req_ex_i, regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} = '0;
    regfile_waddr_ex_i     = '0;
    regfile_alu_waddr_id_i = '0;
    {reg_d_alu_is_reg_c_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_a_i} = '0;
    {reg_d_wb_is_reg_c_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_a_i} = '0;
    {reg_d_ex_is_reg_c_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_a_i} = '0;
    {data_misaligned_i, mult_multicycle_i} = '0;
  endtask

  // comment and blank lines scan as zero fields and are skipped
  task automatic load_trace();
    int          fd;
    int          rc;
    int          cnt;
    string       text;
    logic [15:0] v [NUM_FIELDS];
    fd = $fopen("verif/core_ctrl_trace.txt", "r");
    if (fd == 0)
      abort_run("could not open the trace file verif/core_ctrl_trace.txt");
    n_lines = 0;
    while (!$feof(fd))
    begin
      text = "";
      rc   = $fgets(text, fd);
      cnt  = 0;
      if (rc > 0)
        cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                      v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                      v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
      if (cnt == NUM_FIELDS)
      begin
        for (int k = 0; k < NUM_FIELDS; k++)
          trace_q.push_back(v[k]);
        n_lines++;
      end
      else if (cnt > 0)
        abort_run($sformatf("trace line after cycle %0d has only %0d fields", n_lines, cnt));
    end
    $fclose(fd);
    if (n_lines == 0)
      abort_run("the trace file holds no cycles");
  endtask

  // fields 0 to 8 are the inputs of one cycle
  task automatic drive_inputs(input int idx);
    logic [15:0] f [NUM_FIELDS];
    for (int k = 0; k < NUM_FIELDS; k++)
      f[k] = trace_q[idx * NUM_FIELDS + k];
    {fetch_enable_i, instr_valid_i, id_ready_i, ex_valid_i, wb_ready_i} = f[0][4:0];
    {illegal_insn_i, ecall_insn_i, ebrk_insn_i, mret_insn_i, pipe_flush_i, csr_status_i} =
      f[1][5:0];
    branch_taken_ex_i = f[2][4];
    jump_in_dec_i     = jump_e'(f[2][3:2]);
    jump_in_id_i      = jump_e'(f[2][1:0]);
    {irq_i, irq_req_ctrl_i, m_ie_i, irq_id_ctrl_i} = f[3][7:0];
    {data_req_ex_i, regfile_we_ex_i, regfile_we_wb_i, regfile_alu_we_fw_i} = f[4][3:0];
    regfile_waddr_ex_i     = f[5][5:0];
    regfile_alu_waddr_id_i = f[6][5:0];
    // match bits are alu c b a, wb c b a, ex c b a
    {reg_d_alu_is_reg_c_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_a_i} = f[7][8:6];
    {reg_d_wb_is_reg_c_i, reg_d_wb_is_reg_b_i, reg_d_wb_is_reg_a_i}    = f[7][5:3];
    {reg_d_ex_is_reg_c_i, reg_d_ex_is_reg_b_i, reg_d_ex_is_reg_a_i}    = f[7][2:0];
    {data_misaligned_i, mult_multicycle_i} = f[8][1:0];
  endtask

  // fields 9 to 15 are the expected outputs of the same cycle
  task automatic check_outputs(input int idx);
    logic [15:0] e [NUM_FIELDS];
    for (int k = 0; k < NUM_FIELDS; k++)
      e[k] = trace_q[idx * NUM_FIELDS + k];
    check_value("instr_req_o", e[9][7], instr_req_o);
    check_value("pc_set_o", e[9][6], pc_set_o);
    check_value("pc_mux_o", e[9][5:3], pc_mux_o);
    check_value("exc_pc_mux_o", e[9][2:0], exc_pc_mux_o);
    check_value("ctrl_busy_o", e[10][4], ctrl_busy_o);
    check_value("first_fetch_o", e[10][3], first_fetch_o);
    check_value("is_decoding_o", e[10][2], is_decoding_o);
    check_value("halt_if_o", e[10][1], halt_if_o);
    check_value("halt_id_o", e[10][0], halt_id_o);
    check_value("irq_ack_o", e[11][7], irq_ack_o);
    check_value("exc_ack_o", e[11][6], exc_ack_o);
    check_value("exc_kill_o", e[11][5], exc_kill_o);
    check_value("irq_id_o", e[11][4:0], irq_id_o);
    check_value("csr_save_if_o", e[12][3], csr_save_if_o);
    check_value("csr_save_id_o", e[12][2], csr_save_id_o);
    check_value("csr_save_cause_o", e[12][1], csr_save_cause_o);
    check_value("csr_restore_mret_o", e[12][0], csr_restore_mret_o);
    check_value("csr_cause_o", e[13][5:0], csr_cause_o);
    check_value("deassert_we_o", e[14][2], deassert_we_o);
    check_value("load_stall_o", e[14][1], load_stall_o);
    check_value("jr_stall_o", e[14][0], jr_stall_o);
    check_value("operand_a_fw_sel_o", e[15][5:4], operand_a_fw_sel_o);
    check_value("operand_b_fw_sel_o", e[15][3:2], operand_b_fw_sel_o);
    check_value("operand_c_fw_sel_o", e[15][1:0], operand_c_fw_sel_o);
  endtask

  //////////////////////////////////////////////////////////////////////
  // trace replay
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    loaded  = 1'b0;
    line_no = 0;
    init_inputs();
    load_trace();
    loaded = 1'b1;
    wait (rst_n === 1'b1);
    for (line_no = 1; line_no <= n_lines; line_no++)
    begin
      @(posedge clk);
      #(DRIVE_DELAY);
      drive_inputs(line_no - 1);
      #(CHECK_DELAY);
      check_outputs(line_no - 1);
    end
    $display("*** TEST PASSED ***");
    $finish;
  end

  // trace length plus margin for reset
  initial
  begin
    wait (loaded === 1'b1);
    #((n_lines + 20) * CLK_PERIOD);
    abort_run("watchdog expired because the trace did not finish in time");
  end

endmodule

// File: verif/tb_clk_gen.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Testbench clock and reset
//////////////////////////////////////////////////////////////////////

module tb_clk_gen
#(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 10
)
(
  output logic clk_o,
  output logic rst_n_o
);

  initial
  begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release a quarter period after the last reset edge
  initial
  begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #(PERIOD / 4) rst_n_o = 1'b1;
  end

endmodule

// File: src/core_ctrl.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Core controller top
//////////////////////////////////////////////////////////////////////

`include "ctrl_settings.svh"

module core_ctrl
(
  input  logic                     clk,
  input  logic                     rst_n,

  // pipeline status
  input  logic                     fetch_enable_i,
  input  logic                     instr_valid_i,
  input  logic                     id_ready_i,
  input  logic                     ex_valid_i,
  input  logic                     wb_ready_i,

  // decoder
  input  logic                     illegal_insn_i,
  input  logic                     ecall_insn_i,
  input  logic                     ebrk_insn_i,
  input  logic                     mret_insn_i,
  input  logic                     pipe_flush_i,
  input  logic                     csr_status_i,

  // jumps and branches
  input  logic                     branch_taken_ex_i,
  input  ctrl_pkg::jump_e          jump_in_dec_i,
  input  ctrl_pkg::jump_e          jump_in_id_i,

  // interrupts
  input  logic                     irq_i,
  input  logic                     irq_req_ctrl_i,
  input  logic [`IRQ_ID_W-1:0]     irq_id_ctrl_i,
  input  logic                     m_ie_i,

  // register file writes in flight
  input  logic                     data_req_ex_i,
  input  logic                     regfile_we_ex_i,
  input  logic                     regfile_we_wb_i,
  input  logic                     regfile_alu_we_fw_i,
  input  logic [`REG_ADDR_W-1:0]   regfile_waddr_ex_i,
  input  logic [`REG_ADDR_W-1:0]   regfile_alu_waddr_id_i,

  // destination against source matches
  input  logic                     reg_d_ex_is_reg_a_i,
  input  logic                     reg_d_ex_is_reg_b_i,
  input  logic                     reg_d_ex_is_reg_c_i,
  input  logic                     reg_d_wb_is_reg_a_i,
  input  logic                     reg_d_wb_is_reg_b_i,
  input  logic                     reg_d_wb_is_reg_c_i,
  input  logic                     reg_d_alu_is_reg_a_i,
  input  logic                     reg_d_alu_is_reg_b_i,
  input  logic                     reg_d_alu_is_reg_c_i,

  // lsu and multiplier
  input  logic                     data_misaligned_i,
  input  logic                     mult_multicycle_i,

  // fetch control
  output logic                     instr_req_o,
  output logic                     pc_set_o,
  output ctrl_pkg::pc_mux_e        pc_mux_o,
  output ctrl_pkg::exc_pc_mux_e    exc_pc_mux_o,

  // status
  output logic                     ctrl_busy_o,
  output logic                     first_fetch_o,
  output logic                     is_decoding_o,
  output logic                     halt_if_o,
  output logic                     halt_id_o,

  // interrupt and exception
  output logic                     irq_ack_o,
  output logic [`IRQ_ID_W-1:0]     irq_id_o,
  output logic                     exc_ack_o,
  output logic                     exc_kill_o,

  // csr file
  output logic                     csr_save_if_o,
  output logic                     csr_save_id_o,
  output logic                     csr_save_cause_o,
  output ctrl_pkg::cause_u         csr_cause_o,
  output logic                     csr_restore_mret_o,

  // stalls and forwarding
  output logic                     deassert_we_o,
  output logic                     load_stall_o,
  output logic                     jr_stall_o,
  output ctrl_pkg::fwd_sel_e       operand_a_fw_sel_o,
  output ctrl_pkg::fwd_sel_e       operand_b_fw_sel_o,
  output ctrl_pkg::fwd_sel_e       operand_c_fw_sel_o
);

  rf_hazard_if rf_hz (.clk(clk));

  assign rf_hz.regfile_we_ex        = regfile_we_ex_i;
  assign rf_hz.regfile_we_wb        = regfile_we_wb_i;
  assign rf_hz.regfile_alu_we_fw    = regfile_alu_we_fw_i;
  assign rf_hz.data_req_ex          = data_req_ex_i;
  assign rf_hz.wb_ready             = wb_ready_i;
  assign rf_hz.regfile_waddr_ex     = regfile_waddr_ex_i;
  assign rf_hz.regfile_alu_waddr_id = regfile_alu_waddr_id_i;

  // match vectors packed c, b, a from msb down
  assign rf_hz.ex_hit  = {reg_d_ex_is_reg_c_i,  reg_d_ex_is_reg_b_i,  reg_d_ex_is_reg_a_i};
  assign rf_hz.wb_hit  = {reg_d_wb_is_reg_c_i,  reg_d_wb_is_reg_b_i,  reg_d_wb_is_reg_a_i};
  assign rf_hz.alu_hit = {reg_d_alu_is_reg_c_i, reg_d_alu_is_reg_b_i, reg_d_alu_is_reg_a_i};

  // main FSM, jr stall comes back from the hazard unit
  ctrl_fsm fsm_i (
    .jr_stall_i (jr_stall_o),
    .*
  );

  hazard_unit hazard_i (
    .rf            (rf_hz.hazard),
    .is_decoding_i (is_decoding_o),
    .*
  );

  fwd_unit fwd_i (
    .rf (rf_hz.fwd),
    .*
  );

endmodule

// File: src/fwd_unit.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Forwarding control
//////////////////////////////////////////////////////////////////////

`include "ctrl_settings.svh"

module fwd_unit
(
  rf_hazard_if.fwd         rf,
  input  logic             data_misaligned_i,
  input  logic             mult_multicycle_i,
  output ctrl_pkg::fwd_sel_e operand_a_fw_sel_o,
  output ctrl_pkg::fwd_sel_e operand_b_fw_sel_o,
  output ctrl_pkg::fwd_sel_e operand_c_fw_sel_o
);

  import ctrl_pkg::*;

  // index 0 is operand a, 1 is b, 2 is c
  fwd_sel_e sel [`NUM_OPERANDS];

  always_comb
  begin
    for (int i = 0; i < `NUM_OPERANDS; i++)
    begin
      sel[i] = SEL_REGFILE;
      // WB result
      if (rf.regfile_we_wb && rf.wb_hit[i])
        sel[i] = SEL_FW_WB;
      // younger ALU result overrides WB
      if (rf.regfile_alu_we_fw && rf.alu_hit[i])
        sel[i] = SEL_FW_EX;
    end

    // second half of a misaligned access reuses the EX address
    if (data_misaligned_i)
    begin
      sel[0] = SEL_FW_EX;
      sel[1] = SEL_REGFILE;
    end
    // multicycle multiply keeps its partial result on operand c
    else if (mult_multicycle_i)
      sel[2] = SEL_FW_EX;
  end

  assign operand_a_fw_sel_o = sel[0];
  assign operand_b_fw_sel_o = sel[1];
  assign operand_c_fw_sel_o = sel[2];

endmodule

// File: src/hazard_unit.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Stall control
//////////////////////////////////////////////////////////////////////

module hazard_unit
(
  rf_hazard_if.hazard     rf,
  input  logic            is_decoding_i,
  input  logic            illegal_insn_i,
  input  ctrl_pkg::jump_e jump_in_dec_i,
  output logic            deassert_we_o,
  output logic            load_stall_o,
  output logic            jr_stall_o
);

  import ctrl_pkg::*;

  logic load_pending;
  logic waddr_hit;
  logic rs1_pending;

  // load still in flight in EX, or WB write held by a slow memory
  assign load_pending = (rf.data_req_ex && rf.regfile_we_ex) ||
                        (!rf.wb_ready && rf.regfile_we_wb);

  // decoded instruction writes the same register as the load
  assign waddr_hit = is_decoding_i && (rf.regfile_waddr_ex == rf.regfile_alu_waddr_id);

  assign load_stall_o = load_pending && ((|rf.ex_hit) || waddr_hit);

  // operand a feeds the jalr target, so any pending write to it stalls
  assign rs1_pending = (rf.regfile_we_wb     && rf.wb_hit[0])  ||
                       (rf.regfile_we_ex     && rf.ex_hit[0])  ||
                       (rf.regfile_alu_we_fw && rf.alu_hit[0]);

  assign jr_stall_o = (jump_in_dec_i == BRANCH_JALR) && rs1_pending;

  // kill the write of whatever sits in ID
  assign deassert_we_o = !is_decoding_i || illegal_insn_i || load_stall_o || jr_stall_o;

endmodule

// File: src/ctrl_fsm.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Main controller FSM
//////////////////////////////////////////////////////////////////////

`include "ctrl_settings.svh"

module ctrl_fsm
(
  input  logic                  clk,
  input  logic                  rst_n,

  // boot and pipeline status
  input  logic                  fetch_enable_i,
  input  logic                  instr_valid_i,
  input  logic                  id_ready_i,
  input  logic                  ex_valid_i,

  // decoder flags
  input  logic                  illegal_insn_i,
  input  logic                  ecall_insn_i,
  input  logic                  ebrk_insn_i,
  input  logic                  mret_insn_i,
  input  logic                  pipe_flush_i,
  input  logic                  csr_status_i,

  // jumps and branches
  input  logic                  branch_taken_ex_i,
  input  ctrl_pkg::jump_e       jump_in_dec_i,
  input  ctrl_pkg::jump_e       jump_in_id_i,
  input  logic                  jr_stall_i,

  // interrupt controller
  input  logic                  irq_i,
  input  logic                  irq_req_ctrl_i,
  input  logic [`IRQ_ID_W-1:0]  irq_id_ctrl_i,
  input  logic                  m_ie_i,

  // fetch stage
  output logic                  instr_req_o,
  output logic                  pc_set_o,
  output ctrl_pkg::pc_mux_e     pc_mux_o,
  output ctrl_pkg::exc_pc_mux_e exc_pc_mux_o,

  // status and halts
  output logic                  ctrl_busy_o,
  output logic                  first_fetch_o,
  output logic                  is_decoding_o,
  output logic                  halt_if_o,
  output logic                  halt_id_o,

  // interrupt and exception strobes
  output logic                  irq_ack_o,
  output logic [`IRQ_ID_W-1:0]  irq_id_o,
  output logic                  exc_ack_o,
  output logic                  exc_kill_o,

  // csr file
  output logic                  csr_save_if_o,
  output logic                  csr_save_id_o,
  output logic                  csr_save_cause_o,
  output ctrl_pkg::cause_u      csr_cause_o,
  output logic                  csr_restore_mret_o
);

  import ctrl_pkg::*;

  typedef enum logic [3:0] {
    RESET, BOOT_SET, SLEEP, WAIT_SLEEP, FIRST_FETCH, DECODE,
    IRQ_TAKEN_ID, IRQ_TAKEN_IF, IRQ_FLUSH, FLUSH_EX, FLUSH_WB
  } state_e;

  state_e state_q;
  state_e state_d;
  logic   jump_done_q;
  logic   jump_done_d;
  logic   jump_in_dec;
  logic   irq_enable;
  logic   exc_in_id;

  // only unconditional jumps redirect from decode, branches resolve in EX
  assign jump_in_dec = (jump_in_dec_i == BRANCH_JAL) || (jump_in_dec_i == BRANCH_JALR);
  // machine mode only
  assign irq_enable  = m_ie_i;
  // instruction held in ID that traps to the exception vector
  assign exc_in_id   = ebrk_insn_i | ecall_insn_i | illegal_insn_i;
  assign irq_id_o    = irq_id_ctrl_i;

  //////////////////////////////////////////////////////////////////////
  // next state and outputs
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    state_d            = state_q;
    jump_done_d        = jump_done_q;
    instr_req_o        = 1'b1;
    pc_set_o           = 1'b0;
    pc_mux_o           = PC_BOOT;
    exc_pc_mux_o       = EXC_PC_IRQ;
    ctrl_busy_o        = 1'b1;
    first_fetch_o      = 1'b0;
    is_decoding_o      = 1'b0;
    halt_if_o          = 1'b0;
    halt_id_o          = 1'b0;
    irq_ack_o          = 1'b0;
    exc_ack_o          = 1'b0;
    exc_kill_o         = 1'b0;
    csr_save_if_o      = 1'b0;
    csr_save_id_o      = 1'b0;
    csr_save_cause_o   = 1'b0;
    csr_cause_o        = '0;
    csr_restore_mret_o = 1'b0;

    unique case (state_q)
      // hold the boot address until fetch is enabled
      RESET:
      begin
        instr_req_o = 1'b0;
        pc_set_o    = 1'b1;
        if (fetch_enable_i)
          state_d = BOOT_SET;
      end

      // load boot address into the prefetcher
      BOOT_SET:
      begin
        pc_set_o = 1'b1;
        state_d  = FIRST_FETCH;
      end

      // one idle cycle so the flush settles before sleeping
      WAIT_SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        state_d     = SLEEP;
      end

      // clock may be gated outside, any irq line wakes us
      SLEEP:
      begin
        ctrl_busy_o = 1'b0;
        instr_req_o = 1'b0;
        halt_if_o   = 1'b1;
        halt_id_o   = 1'b1;
        if (irq_i)
          state_d = FIRST_FETCH;
      end

      // wait for the first instruction to reach ID
      FIRST_FETCH:
      begin
        first_fetch_o = 1'b1;
        if (id_ready_i)
          state_d = DECODE;
        // pipeline is empty here, so the trap saves the IF pc
        if (irq_req_ctrl_i && irq_enable)
        begin
          halt_if_o = 1'b1;
          halt_id_o = 1'b1;
          state_d   = IRQ_TAKEN_IF;
        end
      end

      DECODE:
      begin
        if (branch_taken_ex_i)
        begin
          // taken branch in EX wins, the ID instruction is dropped
          pc_mux_o = PC_BRANCH;
          pc_set_o = 1'b1;
        end
        else if (instr_valid_i)
        begin
          is_decoding_o = 1'b1;
          if (irq_req_ctrl_i && irq_enable)
          begin
            halt_if_o = 1'b1;
            halt_id_o = 1'b1;
            state_d   = IRQ_FLUSH;
          end
          else
          begin
            // request seen but masked, tell the irq controller
            exc_kill_o = irq_req_ctrl_i;
            if (jump_in_dec)
            begin
              pc_mux_o = PC_JUMP;
              // one redirect per jump, and only once rs1 is safe
              if (!jr_stall_i && !jump_done_q)
              begin
                pc_set_o    = 1'b1;
                jump_done_d = 1'b1;
              end
            end
            else if (ebrk_insn_i)
            begin
              halt_if_o             = 1'b1;
              halt_id_o             = 1'b1;
              csr_save_id_o         = 1'b1;
              csr_save_cause_o      = 1'b1;
              csr_cause_o.code      = EXC_CAUSE_BREAKPOINT;
              state_d               = FLUSH_EX;
            end
            else if (pipe_flush_i)
            begin
              // wfi, drain and then sleep
              halt_if_o = 1'b1;
              halt_id_o = 1'b1;
              state_d   = FLUSH_EX;
            end
            else if (ecall_insn_i || illegal_insn_i)
            begin
              halt_if_o        = 1'b1;
              halt_id_o        = 1'b1;
              csr_save_id_o    = 1'b1;
              csr_save_cause_o = 1'b1;
              csr_cause_o.code = ecall_insn_i ? EXC_CAUSE_ECALL_MMODE : EXC_CAUSE_ILLEGAL_INSN;
              state_d          = FLUSH_EX;
            end
            else if (mret_insn_i)
            begin
              halt_if_o          = 1'b1;
              halt_id_o          = 1'b1;
              csr_restore_mret_o = 1'b1;
              state_d            = FLUSH_EX;
            end
            else if (csr_status_i)
            begin
              // status csr write, refetch once it has left ID
              halt_if_o = 1'b1;
              if (id_ready_i)
                state_d = FLUSH_EX;
            end
          end
        end
      end

      // let the older instruction in EX finish
      FLUSH_EX:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (ex_valid_i)
          state_d = FLUSH_WB;
      end

      // pipeline is drained, redirect to trap or return address
      FLUSH_WB:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (exc_in_id)
        begin
          pc_set_o     = 1'b1;
          pc_mux_o     = PC_EXCEPTION;
          exc_pc_mux_o = EXC_PC_EXCEPTION;
        end
        else if (mret_insn_i)
        begin
          pc_set_o = 1'b1;
          pc_mux_o = PC_MRET;
        end
        state_d = pipe_flush_i ? WAIT_SLEEP : DECODE;
      end

      IRQ_FLUSH:
      begin
        halt_if_o = 1'b1;
        halt_id_o = 1'b1;
        if (irq_i && irq_enable)
          state_d = IRQ_TAKEN_ID;
        else
        begin
          // interrupt went away during the flush
          exc_kill_o = 1'b1;
          state_d    = DECODE;
        end
      end

      // jump to the vector, save IF or ID pc depending on entry path
      IRQ_TAKEN_ID, IRQ_TAKEN_IF:
      begin
        pc_set_o            = 1'b1;
        pc_mux_o            = PC_EXCEPTION;
        exc_pc_mux_o        = EXC_PC_IRQ;
        csr_save_id_o       = (state_q == IRQ_TAKEN_ID);
        csr_save_if_o       = (state_q == IRQ_TAKEN_IF);
        csr_save_cause_o    = 1'b1;
        csr_cause_o.irq.flag = 1'b1;
        csr_cause_o.irq.id  = irq_id_ctrl_i;
        irq_ack_o           = 1'b1;
        exc_ack_o           = 1'b1;
        state_d             = DECODE;
      end

      default:
      begin
        instr_req_o = 1'b0;
        state_d     = RESET;
      end
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q     <= RESET;
      jump_done_q <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      // jump leaves ID once id_ready rises
      jump_done_q <= jump_done_d & ~id_ready_i;
    end
  end

  // no branch prediction, so the redirect flushes any following branch
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |=> !branch_taken_ex_i);

  // EX can only resolve a branch the decoder passed on a cycle earlier
  assert property (@(posedge clk) disable iff (!rst_n)
    branch_taken_ex_i |-> $past(jump_in_id_i) == BRANCH_COND);

endmodule

// File: src/rf_hazard_if.sv
`timescale 1ns/100ps
//////////////////////////////////////////////////////////////////////
// Register file hazard bundle
//////////////////////////////////////////////////////////////////////

`include "ctrl_settings.svh"

interface rf_hazard_if (input logic clk);

  // pending writes per stage
  logic                     regfile_we_ex;
  logic                     regfile_we_wb;
  logic                     regfile_alu_we_fw;
  logic                     data_req_ex;
  logic                     wb_ready;

  // destination of the EX write and of the decoded instruction
  logic [`REG_ADDR_W-1:0]   regfile_waddr_ex;
  logic [`REG_ADDR_W-1:0]   regfile_alu_waddr_id;

  // bit 0 is operand a, bit 1 b, bit 2 c
  logic [`NUM_OPERANDS-1:0] ex_hit;
  logic [`NUM_OPERANDS-1:0] wb_hit;
  logic [`NUM_OPERANDS-1:0] alu_hit;

  modport hazard (
    input clk, regfile_we_ex, regfile_we_wb, regfile_alu_we_fw, data_req_ex, wb_ready,
    input regfile_waddr_ex, regfile_alu_waddr_id, ex_hit, wb_hit, alu_hit
  );

  modport fwd (
    input regfile_we_ex, regfile_we_wb, regfile_alu_we_fw, ex_hit, wb_hit, alu_hit
  );

endinterface

// File: src/ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Controller types
//////////////////////////////////////////////////////////////////////

`include "ctrl_settings.svh"

package ctrl_pkg;

  // next pc source in the fetch stage
  typedef enum logic [`PC_MUX_W-1:0] {
    PC_BOOT      = 3'b000,
    PC_JUMP      = 3'b010,
    PC_BRANCH    = 3'b011,
    PC_EXCEPTION = 3'b100,
    PC_MRET      = 3'b101
  } pc_mux_e;

  // trap vector offset when pc_mux is PC_EXCEPTION
  typedef enum logic [`PC_MUX_W-1:0] {
    EXC_PC_EXCEPTION = 3'b000,
    EXC_PC_IRQ       = 3'b001
  } exc_pc_mux_e;

  // jump kind from the decoder
  typedef enum logic [1:0] {
    BRANCH_NONE = 2'b00,
    BRANCH_JAL  = 2'b01,
    BRANCH_JALR = 2'b10,
    BRANCH_COND = 2'b11
  } jump_e;

  // operand source in ID
  typedef enum logic [1:0] {
    SEL_REGFILE = 2'b00,
    SEL_FW_EX   = 2'b01,
    SEL_FW_WB   = 2'b10
  } fwd_sel_e;

  // synchronous exception codes
  typedef enum logic [`CAUSE_W-1:0] {
    EXC_CAUSE_ILLEGAL_INSN = 6'h02,
    EXC_CAUSE_BREAKPOINT   = 6'h03,
    EXC_CAUSE_ECALL_MMODE  = 6'h0B
  } exc_code_e;

  // interrupt form of the cause word, msb flags an interrupt
  typedef struct packed {
    logic                 flag;
    logic [`IRQ_ID_W-1:0] id;
  } irq_cause_t;

  // one cause word, read either as exception code or as interrupt
  typedef union packed {
    exc_code_e  code;
    irq_cause_t irq;
  } cause_u;

endpackage

// File: src/ctrl_settings.svh
//////////////////////////////////////////////////////////////////////
// Controller widths
//////////////////////////////////////////////////////////////////////

`ifndef CTRL_SETTINGS_SVH
`define CTRL_SETTINGS_SVH

// register address, including the floating point bank bit
`define REG_ADDR_W    6

// interrupt line id
`define IRQ_ID_W      5

// mcause word as seen by the csr file
`define CAUSE_W       6

// pc and exception pc select
`define PC_MUX_W      3

// operand ports a, b and c
`define NUM_OPERANDS  3

`endif
